//--- rtl/rv64_pkg.sv
// ------------------------------
// RV64I shared definitions
// Instruction formats, opcodes, ALU, load and write-back codes
// ------------------------------
package rv64_pkg;

    localparam int xlen = 64;

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        opc_lui       = 7'b0110111,
        opc_auipc     = 7'b0010111,
        opc_jal       = 7'b1101111,
        opc_jalr      = 7'b1100111,
        opc_branch    = 7'b1100011,
        opc_load      = 7'b0000011,
        opc_store     = 7'b0100011,
        opc_op_imm    = 7'b0010011,
        opc_op        = 7'b0110011,
        opc_op_imm_32 = 7'b0011011,
        opc_op_32     = 7'b0111011
    } opcode_e;

    // ALU function, same code as funct3
    typedef enum logic [2:0] {
        alu_add  = 3'b000,
        alu_sll  = 3'b001,
        alu_slt  = 3'b010,
        alu_sltu = 3'b011,
        alu_xor  = 3'b100,
        alu_srl  = 3'b101,
        alu_or   = 3'b110,
        alu_and  = 3'b111
    } alu_op_e;

    // Load funct3, bit 2 marks zero extension
    typedef enum logic [2:0] {
        ld_b  = 3'b000,
        ld_h  = 3'b001,
        ld_w  = 3'b010,
        ld_d  = 3'b011,
        ld_bu = 3'b100,
        ld_hu = 3'b101,
        ld_wu = 3'b110
    } load_kind_e;

    typedef enum logic [1:0] {
        wb_alu  = 2'b00,
        wb_load = 2'b01,
        wb_pc4  = 2'b10
    } wb_src_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_e    opcode;
    } s_type_t;

    // Branch offset bits scattered over the word
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_type_t;

    // One fetched word, seen in every format
    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } rv_instr_t;

endpackage

//--- rtl/core_ctrl_if.sv
`timescale 1ns/1ps
// ------------------------------
// Core control interface
// Datapath controls out of decode, ALU flags back
// ------------------------------
interface core_ctrl_if
    import rv64_pkg::*;
();

    logic    alua_pc;
    logic    alub_reg;
    alu_op_e alu_op;
    logic    sub;
    logic    arithmetic;
    logic    word_op;
    logic    pc_target;
    logic    jalr;
    logic    pc_enable;
    logic    reg_write;

    // Flags of the ALU adder
    logic    zero;
    logic    negative;
    logic    carry_out;
    logic    overflow;

    modport decode (
        output alua_pc, alub_reg, alu_op, sub, arithmetic, word_op,
        output pc_target, jalr, pc_enable, reg_write,
        input  zero, negative, carry_out, overflow
    );

    modport execute (
        input  alua_pc, alub_reg, alu_op, sub, arithmetic, word_op,
        input  pc_target, jalr, pc_enable, reg_write,
        output zero, negative, carry_out, overflow
    );

endinterface

//--- rtl/rv_result_if.sv
`timescale 1ns/1ps
// ------------------------------
// Execute to result interface
// ------------------------------
interface rv_result_if
    import rv64_pkg::*;
();

    logic [xlen-1:0] alu_y;
    logic [xlen-1:0] pc_plus_4;
    // Value written back to rd
    logic [xlen-1:0] rd_data;

    modport execute (
        output alu_y, pc_plus_4,
        input  rd_data
    );

    modport result (
        input  alu_y, pc_plus_4,
        output rd_data
    );

endinterface

//--- rtl/rv_decode.sv
`timescale 1ns/1ps
// ------------------------------
// RV64I decode
// Control unit of the single-cycle core
// ------------------------------
module rv_decode
    import rv64_pkg::*;
(
    input  rv_instr_t   instruction,
    core_ctrl_if.decode ctrl,
    output logic        mem_write,
    output logic [1:0]  mem_size,
    output load_kind_e  load_kind,
    output wb_src_e     wb_src,
    output logic        halted
);

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       cond;
    logic       branch_taken;
    logic       is_slt;

    assign funct3 = instruction.r.funct3;
    assign funct7 = instruction.r.funct7;
    // SLT and SLTU need the subtraction
    assign is_slt = (funct3 == 3'b010) || (funct3 == 3'b011);

    // Branch test on the rs1 - rs2 flags
    always_comb begin
        if (!funct3[2])
            cond = ctrl.zero;
        else if (!funct3[1])
            cond = ctrl.negative ^ ctrl.overflow;
        else
            cond = ~ctrl.carry_out;
    end

    // BNE, BGE and BGEU invert the test
    assign branch_taken = cond ^ funct3[0];

    always_comb begin
        ctrl.alua_pc    = 1'b0;
        ctrl.alub_reg   = 1'b0;
        ctrl.alu_op     = alu_add;
        ctrl.sub        = 1'b0;
        ctrl.arithmetic = 1'b0;
        ctrl.word_op    = 1'b0;
        ctrl.pc_target  = 1'b0;
        ctrl.jalr       = 1'b0;
        ctrl.pc_enable  = 1'b1;
        ctrl.reg_write  = 1'b0;
        mem_write       = 1'b0;
        mem_size        = funct3[1:0];
        load_kind       = load_kind_e'(funct3);
        wb_src          = wb_alu;
        halted          = 1'b0;
        case (instruction.r.opcode)
            // rs1 is masked to x0 in execute
            opc_lui:
                ctrl.reg_write = 1'b1;
            opc_auipc: begin
                ctrl.alua_pc   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            opc_jal, opc_jalr: begin
                ctrl.pc_target = 1'b1;
                ctrl.jalr      = (instruction.r.opcode == opc_jalr);
                ctrl.reg_write = 1'b1;
                wb_src         = wb_pc4;
            end
            opc_branch: begin
                ctrl.alub_reg  = 1'b1;
                ctrl.sub       = 1'b1;
                ctrl.pc_target = branch_taken;
            end
            opc_load: begin
                ctrl.reg_write = 1'b1;
                wb_src         = wb_load;
            end
            opc_store:
                mem_write = 1'b1;
            opc_op_imm, opc_op_imm_32, opc_op, opc_op_32: begin
                ctrl.alub_reg   = instruction.r.opcode[5];
                ctrl.alu_op     = alu_op_e'(funct3);
                ctrl.arithmetic = funct7[5];
                ctrl.word_op    = instruction.r.opcode[3];
                ctrl.sub        = is_slt ||
                                  (instruction.r.opcode[5] && funct3 == 3'b000 && funct7[5]);
                ctrl.reg_write  = 1'b1;
            end
            // Unsupported word, hold the PC
            default: begin
                ctrl.pc_enable = 1'b0;
                halted         = 1'b1;
            end
        endcase
    end

    no_store_and_write: assert final (!(mem_write && ctrl.reg_write))
        else $error("store and register write decoded together");

endmodule

//--- rtl/rv_execute.sv
`timescale 1ns/1ps
// ------------------------------
// RV64I execute
// Register file, immediates, ALU and PC
// ------------------------------
module rv_execute
    import rv64_pkg::*;
#(
    parameter logic [xlen-1:0] reset_vector = '0
) (
    input  logic            clock,
    input  logic            rst,
    input  rv_instr_t       instruction,
    core_ctrl_if.execute    ctrl,
    rv_result_if.execute    res,
    output logic [xlen-1:0] instruction_address,
    output logic [xlen-1:0] data_address,
    output logic [xlen-1:0] write_data
);

    logic [xlen-1:0] regs [32];
    logic [4:0]      rs1_idx;
    logic [4:0]      rs2_idx;
    logic [4:0]      rd_idx;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] immediate;
    logic [xlen-1:0] alu_a;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] b_eff;
    logic [xlen:0]   sum_ext;
    logic [xlen-1:0] sum;
    logic            overflow;
    logic [xlen-1:0] shift_src;
    logic [5:0]      shamt;
    logic [xlen-1:0] sra_res;
    logic [xlen-1:0] alu_raw;
    logic [xlen-1:0] alu_y;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_plus_4;
    logic [xlen-1:0] target_sum;
    logic [xlen-1:0] next_pc;

    // LUI and AUIPC read x0 as rs1
    assign rs1_idx  = instruction.r.rs1 & {5{~(instruction[4] & instruction[2])}};
    assign rs2_idx  = instruction.r.rs2;
    assign rd_idx   = instruction.r.rd;
    assign rs1_data = regs[rs1_idx];
    assign rs2_data = regs[rs2_idx];

    always_comb begin
        case (instruction.r.opcode)
            opc_lui, opc_auipc:
                immediate = {{32{instruction.u.imm_31_12[19]}}, instruction.u.imm_31_12, 12'b0};
            opc_jal:
                immediate = {{44{instruction.j.imm_20}}, instruction.j.imm_19_12,
                             instruction.j.imm_11, instruction.j.imm_10_1, 1'b0};
            opc_branch:
                immediate = {{52{instruction.b.imm_12}}, instruction.b.imm_11,
                             instruction.b.imm_10_5, instruction.b.imm_4_1, 1'b0};
            opc_store:
                immediate = {{52{instruction.s.imm_11_5[6]}}, instruction.s.imm_11_5,
                             instruction.s.imm_4_0};
            default:
                immediate = {{52{instruction.i.imm[11]}}, instruction.i.imm};
        endcase
    end

    assign alu_a = ctrl.alua_pc ? pc : rs1_data;
    assign alu_b = ctrl.alub_reg ? rs2_data : immediate;

    // One adder for add, sub, compares and branch flags
    assign b_eff    = ctrl.sub ? ~alu_b : alu_b;
    assign sum_ext  = {1'b0, alu_a} + {1'b0, b_eff} + {{xlen{1'b0}}, ctrl.sub};
    assign sum      = sum_ext[xlen-1:0];
    assign overflow = (alu_a[xlen-1] == b_eff[xlen-1]) && (sum[xlen-1] != alu_a[xlen-1]);

    assign ctrl.zero      = (sum == '0);
    assign ctrl.negative  = sum[xlen-1];
    assign ctrl.carry_out = sum_ext[xlen];
    assign ctrl.overflow  = overflow;

    // Word shifts see only the low 32 bits
    always_comb begin
        if (!ctrl.word_op)
            shift_src = alu_a;
        else if (ctrl.arithmetic)
            shift_src = {{32{alu_a[31]}}, alu_a[31:0]};
        else
            shift_src = {32'b0, alu_a[31:0]};
    end

    assign shamt   = ctrl.word_op ? {1'b0, alu_b[4:0]} : alu_b[5:0];
    assign sra_res = $signed(shift_src) >>> shamt;

    always_comb begin
        case (ctrl.alu_op)
            alu_add:  alu_raw = sum;
            alu_sll:  alu_raw = shift_src << shamt;
            alu_slt:  alu_raw = {{(xlen-1){1'b0}}, sum[xlen-1] ^ overflow};
            alu_sltu: alu_raw = {{(xlen-1){1'b0}}, ~sum_ext[xlen]};
            alu_xor:  alu_raw = alu_a ^ alu_b;
            alu_srl:  alu_raw = ctrl.arithmetic ? sra_res : (shift_src >> shamt);
            alu_or:   alu_raw = alu_a | alu_b;
            alu_and:  alu_raw = alu_a & alu_b;
        endcase
    end

    assign alu_y = ctrl.word_op ? {{32{alu_raw[31]}}, alu_raw[31:0]} : alu_raw;

    // Target adder, JALR clears bit 0 of the sum
    assign pc_plus_4  = pc + 64'd4;
    assign target_sum = (ctrl.jalr ? rs1_data : pc) + immediate;
    assign next_pc    = ctrl.pc_target ? {target_sum[xlen-1:1], target_sum[0] & ~ctrl.jalr}
                                       : pc_plus_4;

    always_ff @(posedge clock) begin
        if (rst) begin
            pc <= reset_vector;
        end else if (ctrl.pc_enable) begin
            pc <= next_pc;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.reg_write && rd_idx != 5'd0) begin
            regs[rd_idx] <= res.rd_data;
        end
    end

    assign res.alu_y           = alu_y;
    assign res.pc_plus_4       = pc_plus_4;
    assign instruction_address = pc;
    assign data_address        = alu_y;
    assign write_data          = rs2_data;

    x0_reads_zero: assert property (@(posedge clock) disable iff (rst)
        (rs2_idx == 5'd0) |-> (rs2_data == '0));

    pc_aligned: assert property (@(posedge clock) disable iff (rst)
        pc[1:0] == 2'b00);

endmodule

//--- rtl/rv_result.sv
`timescale 1ns/1ps
// ------------------------------
// RV64I result stage
// Load extension and write-back select
// ------------------------------
module rv_result
    import rv64_pkg::*;
(
    input  logic [xlen-1:0] read_data,
    input  load_kind_e      load_kind,
    input  wb_src_e         wb_src,
    rv_result_if.result     res
);

    logic [xlen-1:0] load_ext;

    // Memory returns the value right-aligned
    always_comb begin
        case (load_kind)
            ld_b:    load_ext = {{56{read_data[7]}}, read_data[7:0]};
            ld_h:    load_ext = {{48{read_data[15]}}, read_data[15:0]};
            ld_w:    load_ext = {{32{read_data[31]}}, read_data[31:0]};
            ld_bu:   load_ext = {56'b0, read_data[7:0]};
            ld_hu:   load_ext = {48'b0, read_data[15:0]};
            ld_wu:   load_ext = {32'b0, read_data[31:0]};
            default: load_ext = read_data;
        endcase
    end

    always_comb begin
        case (wb_src)
            wb_load: res.rd_data = load_ext;
            wb_pc4:  res.rd_data = res.pc_plus_4;
            default: res.rd_data = res.alu_y;
        endcase
    end

    legal_load_kind: assert final (wb_src != wb_load ||
        load_kind inside {ld_b, ld_h, ld_w, ld_d, ld_bu, ld_hu, ld_wu})
        else $error("load with reserved funct3 %b", load_kind);

endmodule

//--- rtl/rv_core.sv
`timescale 1ns/1ps
// ------------------------------
// RV64I single-cycle core
// Decode, execute and result around external memories
// ------------------------------
module rv_core
    import rv64_pkg::*;
#(
    parameter logic [xlen-1:0] reset_vector = '0
) (
    input  logic            clock,
    input  logic            rst,
    input  logic [31:0]     instruction,
    output logic [xlen-1:0] instruction_address,
    input  logic [xlen-1:0] read_data,
    output logic [xlen-1:0] data_address,
    output logic [xlen-1:0] write_data,
    output logic            mem_write,
    output logic [1:0]      mem_size,
    output logic            halted,
    output logic [xlen-1:0] db_reg_data
);

    load_kind_e load_kind;
    wb_src_e    wb_src;

    core_ctrl_if ctrl ();
    rv_result_if res ();

    rv_decode u_decode (
        .instruction (instruction),
        .ctrl        (ctrl),
        .mem_write   (mem_write),
        .mem_size    (mem_size),
        .load_kind   (load_kind),
        .wb_src      (wb_src),
        .halted      (halted)
    );

    rv_execute #(
        .reset_vector (reset_vector)
    ) u_execute (
        .clock               (clock),
        .rst                 (rst),
        .instruction         (instruction),
        .ctrl                (ctrl),
        .res                 (res),
        .instruction_address (instruction_address),
        .data_address        (data_address),
        .write_data          (write_data)
    );

    rv_result u_result (
        .read_data (read_data),
        .load_kind (load_kind),
        .wb_src    (wb_src),
        .res       (res)
    );

    // Debug view of the rd write value
    assign db_reg_data = res.rd_data;

endmodule

//--- tb/rv_checker.sv
`timescale 1ns/1ps
// ------------------------------
// RV64I core checker
// Reference ISA model, compared with the DUT every cycle
// ------------------------------
module rv_checker #(
    parameter logic [63:0] reset_vector = '0
) (
    input logic        clock,
    input logic        rst,
    input logic [31:0] instruction,
    input logic [63:0] instruction_address,
    input logic [63:0] data_address,
    input logic [63:0] write_data,
    input logic        mem_write,
    input logic [1:0]  mem_size,
    input logic        halted,
    input logic [63:0] db_reg_data
);

    logic [63:0] m_pc;
    logic [63:0] m_x [32];
    logic [7:0]  m_mem [512];
    logic        e_wr, e_ld, e_rd_we, e_halt;
    logic [63:0] e_addr, e_wdata, e_rd;
    logic [1:0]  e_size;
    int          check_count = 0;
    int          error_count = 0;

    function automatic logic [7:0] fill_byte(input int i);
        return 8'((i * 29) ^ (i >> 8));
    endfunction

    function automatic logic [63:0] alu(input logic [63:0] a, input logic [63:0] b,
                                        input logic [2:0] f3, input logic alt, input logic word);
        logic [31:0] w32;
        logic [63:0] r;
        w32 = '0;
        if (word) begin
            case (f3)
                3'd0: w32 = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
                3'd1: w32 = a[31:0] << b[4:0];
                3'd5: begin
                    if (alt)
                        w32 = $signed(a[31:0]) >>> b[4:0];
                    else
                        w32 = a[31:0] >> b[4:0];
                end
                default: w32 = '0;
            endcase
            r = {{32{w32[31]}}, w32};
        end else begin
            case (f3)
                3'd0: r = alt ? a - b : a + b;
                3'd1: r = a << b[5:0];
                3'd2: r = {63'b0, $signed(a) < $signed(b)};
                3'd3: r = {63'b0, a < b};
                3'd4: r = a ^ b;
                3'd5: begin
                    if (alt)
                        r = $signed(a) >>> b[5:0];
                    else
                        r = a >> b[5:0];
                end
                3'd6: r = a | b;
                default: r = a & b;
            endcase
        end
        return r;
    endfunction

    // One instruction on the private model
    function automatic void rv_step(input logic [31:0] w);
        logic [2:0]  f3;
        logic [63:0] a, b, ii, is_, ib, iu, ij, addr, ld, r, next;
        logic        take;
        f3 = w[14:12];
        a = m_x[w[19:15]];
        b = m_x[w[24:20]];
        ii = {{52{w[31]}}, w[31:20]};
        is_ = {{52{w[31]}}, w[31:25], w[11:7]};
        ib = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        iu = {{32{w[31]}}, w[31:12], 12'b0};
        ij = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        e_wr = 0;
        e_ld = 0;
        e_rd_we = 1;
        e_halt = 0;
        e_size = 0;
        e_addr = 0;
        e_wdata = 0;
        r = 0;
        next = m_pc + 4;
        case (w[6:0])
            7'h37: r = iu;
            7'h17: r = m_pc + iu;
            7'h6f: begin
                r = m_pc + 4;
                next = m_pc + ij;
            end
            7'h67: begin
                r = m_pc + 4;
                next = (a + ii) & ~64'd1;
            end
            7'h63: begin
                e_rd_we = 0;
                case (f3)
                    3'd0: take = (a == b);
                    3'd1: take = (a != b);
                    3'd4: take = $signed(a) < $signed(b);
                    3'd5: take = $signed(a) >= $signed(b);
                    3'd6: take = a < b;
                    default: take = a >= b;
                endcase
                if (take)
                    next = m_pc + ib;
            end
            7'h03: begin
                addr = a + ii;
                for (int k = 0; k < 8; k++)
                    ld[8*k +: 8] = m_mem[(addr + k) % 512];
                case (f3)
                    3'd0: r = {{56{ld[7]}}, ld[7:0]};
                    3'd1: r = {{48{ld[15]}}, ld[15:0]};
                    3'd2: r = {{32{ld[31]}}, ld[31:0]};
                    3'd4: r = {56'b0, ld[7:0]};
                    3'd5: r = {48'b0, ld[15:0]};
                    3'd6: r = {32'b0, ld[31:0]};
                    default: r = ld;
                endcase
                e_ld = 1;
                e_addr = addr;
            end
            7'h23: begin
                e_rd_we = 0;
                e_wr = 1;
                e_addr = a + is_;
                e_wdata = b;
                e_size = f3[1:0];
                for (int k = 0; k < (1 << f3[1:0]); k++)
                    m_mem[(e_addr + k) % 512] = b[8*k +: 8];
            end
            7'h13: r = alu(a, ii, f3, f3 == 3'd5 && w[30], 1'b0);
            7'h33: r = alu(a, b, f3, w[30], 1'b0);
            7'h1b: r = alu(a, ii, f3, f3 == 3'd5 && w[30], 1'b1);
            7'h3b: r = alu(a, b, f3, w[30], 1'b1);
            default: begin
                e_rd_we = 0;
                e_halt = 1;
                next = m_pc;
            end
        endcase
        e_rd = r;
        if (e_rd_we && w[11:7] != 5'd0)
            m_x[w[11:7]] = r;
        m_pc = next;
    endfunction

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        check_count++;
        if (exp !== act) begin
            error_count++;
            $display("Error at %0t: %s expected %h, actual %h", $time, name, exp, act);
        end
    endtask

    initial begin
        for (int i = 0; i < 512; i++)
            m_mem[i] = fill_byte(i);
    end

    // Outputs are settled at the falling edge
    always @(negedge clock) begin
        if (rst) begin
            m_pc = reset_vector;
            for (int i = 0; i < 32; i++)
                m_x[i] = '0;
        end else begin
            check("instruction_address", m_pc, instruction_address);
            rv_step(instruction);
            check("halted", e_halt, halted);
            check("mem_write", e_wr, mem_write);
            if (e_wr || e_ld)
                check("data_address", e_addr, data_address);
            if (e_wr) begin
                check("write_data", e_wdata, write_data);
                check("mem_size", e_size, mem_size);
            end
            if (e_rd_we)
                check("db_reg_data", e_rd, db_reg_data);
        end
    end

endmodule

//--- tb/tb_rv_core.sv
`timescale 1ns/1ps
// ------------------------------
// RV64I core testbench
// Memories, program generation and the DUT
// ------------------------------
module tb_rv_core;

    logic        clock, rst, mem_write, halted;
    logic [31:0] instruction;
    logic [63:0] instruction_address, read_data, data_address, write_data, db_reg_data;
    logic [1:0]  mem_size;
    logic [31:0] imem [256];
    logic [7:0]  dmem [512];
    integer      seed;
    int          wp;
    int          cycles;

    rv_core #(.reset_vector(64'h0)) uut (
        .clock(clock), .rst(rst), .instruction(instruction),
        .instruction_address(instruction_address), .read_data(read_data),
        .data_address(data_address), .write_data(write_data), .mem_write(mem_write),
        .mem_size(mem_size), .halted(halted), .db_reg_data(db_reg_data)
    );

    rv_checker #(.reset_vector(64'h0)) chk (
        .clock(clock), .rst(rst), .instruction(instruction),
        .instruction_address(instruction_address), .data_address(data_address),
        .write_data(write_data), .mem_write(mem_write), .mem_size(mem_size),
        .halted(halted), .db_reg_data(db_reg_data)
    );

    // Combinational memory reads, loads right-aligned
    assign instruction = imem[instruction_address[9:2]];
    for (genvar gk = 0; gk < 8; gk++) begin : g_read
        assign read_data[8*gk +: 8] = dmem[(data_address + gk) % 512];
    end

    always @(posedge clock) begin
        if (mem_write)
            for (int k = 0; k < (1 << mem_size); k++)
                dmem[(data_address + k) % 512] <= write_data[8*k +: 8];
    end

    function automatic int rnd(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
            input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
            input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    task automatic emit(input logic [31:0] w);
        imem[wp] = w;
        wp++;
    endtask

    task automatic build_program();
        logic [31:0] skip;
        int          f3, op;
        logic [11:0] imm;
        skip = enc_i(12'd1, 5'd12, 3'd0, 5'd12, 7'h13);
        wp = 0;
        for (int i = 1; i <= 8; i++) begin
            emit(enc_u(20'(rnd(1 << 20)), 5'(i), 7'h37));
            emit(enc_i(12'(rnd(4096)), 5'(i), 3'd0, 5'(i), 7'h13));
            emit(enc_i({6'b0, 6'(rnd(64))}, 5'(i), 3'd1, 5'(i), 7'h13));
        end
        // x9 = most negative, x11 = most positive
        emit(enc_u(20'h80000, 5'd9, 7'h37));
        emit(enc_i(12'd32, 5'd9, 3'd1, 5'd9, 7'h13));
        emit(enc_i(12'hfff, 5'd9, 3'd0, 5'd11, 7'h13));
        emit(enc_r(7'h00, 5'd11, 5'd9, 3'd2, 5'd12, 7'h33));
        emit(enc_r(7'h00, 5'd11, 5'd9, 3'd3, 5'd12, 7'h33));
        emit(enc_r(7'h00, 5'd9, 5'd11, 3'd2, 5'd12, 7'h33));
        emit(enc_r(7'h00, 5'd9, 5'd11, 3'd3, 5'd12, 7'h33));
        emit(enc_i({6'b010000, 6'd63}, 5'd9, 3'd5, 5'd12, 7'h13));
        emit(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd12, 7'h3b));
        emit(enc_r(7'h20, 5'd4, 5'd3, 3'd5, 5'd12, 7'h3b));
        emit(enc_i(12'd7, 5'd5, 3'd1, 5'd12, 7'h1b));
        emit(enc_r(7'h00, 5'd7, 5'd6, 3'd0, 5'd12, 7'h3b));
        for (int i = 0; i < 40; i++) begin
            op = rnd(4);
            f3 = (op % 2 == 0) ? rnd(8) : rnd(3);
            if (op % 2 == 1 && f3 == 2)
                f3 = 5;
            imm = 12'(rnd(4096));
            if (f3 == 1)
                imm = (op == 3) ? {7'b0, 5'(rnd(32))} : {6'b0, 6'(rnd(64))};
            else if (f3 == 5)
                imm = (op == 3) ? {1'b0, 1'(rnd(2)), 5'b0, 5'(rnd(32))}
                                : {1'b0, 1'(rnd(2)), 4'b0, 6'(rnd(64))};
            if (op < 2)
                emit(enc_r(((f3 == 0 || f3 == 5) && rnd(2) == 1) ? 7'h20 : 7'h00,
                           5'(1 + rnd(11)), 5'(1 + rnd(11)), 3'(f3), 5'(rnd(9)),
                           op == 0 ? 7'h33 : 7'h3b));
            else
                emit(enc_i(imm, 5'(1 + rnd(11)), 3'(f3), 5'(rnd(9)),
                           op == 2 ? 7'h13 : 7'h1b));
        end
        // Memory traffic around base x10
        emit(enc_i(12'd256, 5'd0, 3'd0, 5'd10, 7'h13));
        for (int i = 0; i < 8; i++)
            emit(enc_s(12'(8 * rnd(16)), 5'(1 + rnd(8)), 5'd10, 3'(i % 4)));
        for (int i = 0; i < 14; i++)
            emit(enc_i(12'(rnd(128) & ~((1 << ((i % 7) & 3)) - 1)), 5'd10, 3'(i % 7),
                       5'd12, 7'h03));
        for (int c = 0; c < 8; c++) begin
            if (c != 2 && c != 3) begin
                emit(enc_b(13'd8, 5'd11, 5'd9, 3'(c)));
                emit(skip);
                emit(enc_b(13'd8, 5'd9, 5'd11, 3'(c)));
                emit(skip);
                emit(enc_b(13'd8, 5'd1, 5'd1, 3'(c)));
                emit(skip);
            end
        end
        // Forward jumps, a backward BNE and a backward JAL
        emit(enc_j(21'd8, 5'd13));
        emit(enc_j(21'd8, 5'd0));
        emit(enc_b(13'h1ffc, 5'd11, 5'd9, 3'd1));
        emit(enc_j(21'd8, 5'd13));
        emit(enc_j(21'd8, 5'd0));
        emit(enc_j(21'h1ffffc, 5'd13));
        emit(enc_u(20'(rnd(1 << 20)), 5'd14, 7'h17));
        // JALR from an odd base
        emit(enc_u(20'd0, 5'd15, 7'h17));
        emit(enc_i(12'd17, 5'd15, 3'd0, 5'd15, 7'h13));
        emit(enc_i(12'd0, 5'd15, 3'd0, 5'd16, 7'h67));
        emit(skip);
        emit(enc_u(20'(rnd(1 << 20)), 5'd17, 7'h37));
        emit(32'h0000_0000);
    endtask

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    initial begin
        seed = 32'he9a1;
        rst = 1'b1;
        for (int i = 0; i < 256; i++)
            imem[i] = 32'h0;
        for (int i = 0; i < 512; i++)
            dmem[i] = 8'((i * 29) ^ (i >> 8));
        build_program();
        repeat (5) @(posedge clock);
        rst <= 1'b0;
        cycles = 0;
        @(negedge clock);
        while (!halted && cycles < 2000) begin
            @(negedge clock);
            cycles++;
        end
        if (!halted) begin
            $display("Core never halted within 2000 cycles");
            $display("TEST FAIL");
        end else begin
            // PC must stay frozen while halted
            repeat (4) @(negedge clock);
            $display("Checks: %0d, errors: %0d", chk.check_count, chk.error_count);
            if (chk.error_count == 0)
                $display("TEST PASS");
            else
                $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- project.f
rtl/rv64_pkg.sv
rtl/core_ctrl_if.sv
rtl/rv_result_if.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/rv_result.sv
rtl/rv_core.sv
tb/rv_checker.sv
tb/tb_rv_core.sv

//--- Bender.yml
package:
  name: rv64_core

sources:
  - rtl/rv64_pkg.sv
  - rtl/core_ctrl_if.sv
  - rtl/rv_result_if.sv
  - rtl/rv_decode.sv
  - rtl/rv_execute.sv
  - rtl/rv_result.sv
  - rtl/rv_core.sv
  - target: test
    files:
      - tb/rv_checker.sv
      - tb/tb_rv_core.sv
